// File: bench/jtag_debug_chk.sv
// Wishbone and request assertions
`timescale 1ns/1ps

module jtag_debug_chk (
    input logic                               jtag_tck_i,
    input logic                               jtag_trst_ni,
    input logic                               req_i,
    input logic                               cyc_i,
    input logic                               stb_i,
    input logic [jtag_pkg::DMI_ADDR_BITS-1:0] adr_i,
    input logic [jtag_pkg::DMI_DATA_BITS-1:0] dat_i,
    input logic                               ack_i
);

    int fail_count = 0;    // Number of failed assertions

    a_stb_needs_cyc: assert property (@(posedge jtag_tck_i) disable iff (!jtag_trst_ni)
        stb_i |-> cyc_i)
        else begin
            $error("Wishbone stb high without cyc");
            fail_count++;
        end

    // Master holds the cycle until ack is seen
    a_hold_until_ack: assert property (@(posedge jtag_tck_i) disable iff (!jtag_trst_ni)
        (cyc_i && stb_i && !ack_i) |=> (cyc_i && stb_i && $stable(adr_i) && $stable(dat_i)))
        else begin
            $error("Wishbone cycle changed before ack");
            fail_count++;
        end

    a_ack_single: assert property (@(posedge jtag_tck_i) disable iff (!jtag_trst_ni)
        ack_i |=> !ack_i)
        else begin
            $error("Wishbone ack longer than one cycle");
            fail_count++;
        end

    a_req_single: assert property (@(posedge jtag_tck_i) disable iff (!jtag_trst_ni)
        req_i |=> !req_i)
        else begin
            $error("DMI request pulse longer than one cycle");
            fail_count++;
        end

endmodule

bind jtag_dtm jtag_debug_chk i_chk_master (
    .jtag_tck_i   (jtag_tck_i),
    .jtag_trst_ni (jtag_trst_ni),
    .req_i        (tap_req_i),
    .cyc_i        (wb_cyc_o),
    .stb_i        (wb_stb_o),
    .adr_i        (wb_adr_o),
    .dat_i        (wb_dat_o),
    .ack_i        (wb_ack_i)
);

bind dm_reg_file jtag_debug_chk i_chk_slave (
    .jtag_tck_i   (jtag_tck_i),
    .jtag_trst_ni (jtag_trst_ni),
    .req_i        (1'b0),           // No request on the slave side
    .cyc_i        (wb_cyc_i),
    .stb_i        (wb_stb_i),
    .adr_i        (wb_adr_i),
    .dat_i        (wb_dat_i),
    .ack_i        (wb_ack_o)
);

// File: bench/jtag_debug_tb.sv
// JTAG debug transport testbench
`timescale 1ns/1ps

module jtag_debug_tb;

    localparam int STATUS_TRIES = 8;    // NOP scans before giving up on busy
    localparam int BYPASS_BITS  = 24;
    localparam int ADDR_MAX     = (1 << jtag_pkg::DMI_ADDR_BITS) - 1;

    logic jtag_tck;
    logic jtag_tms;
    logic jtag_tdi;
    logic jtag_trst_n;
    logic jtag_tdo;

    int   check_count;
    int   err_count;
    logic [jtag_pkg::DMI_DATA_BITS-1:0] model [jtag_pkg::REG_DEPTH];  // Expected register words

    jtag_debug_top i_dut (
        .jtag_tck_i   (jtag_tck),
        .jtag_tms_i   (jtag_tms),
        .jtag_tdi_i   (jtag_tdi),
        .jtag_trst_ni (jtag_trst_n),
        .jtag_tdo_o   (jtag_tdo)
    );

    initial jtag_tck = 1'b0;
    always #2 jtag_tck = ~jtag_tck;

    // Address on top, data in the middle, op in the low bits
    function automatic logic [jtag_pkg::DMI_BITS-1:0] dmi_word(
        input logic [jtag_pkg::DMI_ADDR_BITS-1:0] addr,
        input logic [jtag_pkg::DMI_DATA_BITS-1:0] data,
        input logic [jtag_pkg::DMI_OP_BITS-1:0]   op);
        return {addr, data, op};
    endfunction

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One TCK period, TDO sampled on the rising edge
    task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
        @(negedge jtag_tck);
        jtag_tms = tms;
        jtag_tdi = tdi;
        @(posedge jtag_tck);
        tdo = jtag_tdo;
    endtask

    task automatic run_idle(input int cycles);
        logic unused;
        repeat (cycles) tck_cycle(1'b0, 1'b0, unused);
    endtask

    task automatic tap_reset();
        logic unused;
        repeat (5) tck_cycle(1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);      // Run-Test-Idle
    endtask

    task automatic shift_ir(input logic [jtag_pkg::IR_BITS-1:0] ir,
                            output logic [jtag_pkg::IR_BITS-1:0] captured);
        logic unused;
        logic bit_out;
        tck_cycle(1'b1, 1'b0, unused);      // Select-DR
        tck_cycle(1'b1, 1'b0, unused);      // Select-IR
        tck_cycle(1'b0, 1'b0, unused);      // Capture-IR
        tck_cycle(1'b0, 1'b0, unused);
        for (int i = 0; i < jtag_pkg::IR_BITS; i++) begin
            tck_cycle(i == jtag_pkg::IR_BITS - 1, ir[i], bit_out);
            captured[i] = bit_out;
        end
        tck_cycle(1'b1, 1'b0, unused);      // Update-IR
        tck_cycle(1'b0, 1'b0, unused);
    endtask

    // Optional detour through Pause-DR after bit pause_at-1
    task automatic shift_dr(input logic [63:0] data_in, input int nbits, input int pause_at,
                            output logic [63:0] captured);
        logic unused;
        logic bit_out;
        logic leave;
        captured = '0;
        tck_cycle(1'b1, 1'b0, unused);      // Select-DR
        tck_cycle(1'b0, 1'b0, unused);      // Capture-DR
        tck_cycle(1'b0, 1'b0, unused);
        for (int i = 0; i < nbits; i++) begin
            leave = (i == nbits - 1) || (i == pause_at - 1);
            tck_cycle(leave, data_in[i], bit_out);
            captured[i] = bit_out;
            if ((i == pause_at - 1) && (i != nbits - 1)) begin
                tck_cycle(1'b0, 1'b0, unused);  // Pause-DR
                tck_cycle(1'b0, 1'b0, unused);
                tck_cycle(1'b1, 1'b0, unused);  // Exit2-DR
                tck_cycle(1'b0, 1'b0, unused);  // Back to Shift-DR
            end
        end
        tck_cycle(1'b1, 1'b0, unused);      // Update-DR
        tck_cycle(1'b0, 1'b0, unused);
    endtask

    task automatic dmi_access(input logic [jtag_pkg::DMI_ADDR_BITS-1:0] addr,
                              input logic [jtag_pkg::DMI_DATA_BITS-1:0] data,
                              input logic [jtag_pkg::DMI_OP_BITS-1:0] op, input int pause_at,
                              output logic [jtag_pkg::DMI_BITS-1:0] resp);
        logic [63:0] cap;
        shift_dr(64'(dmi_word(addr, data, op)), jtag_pkg::DMI_BITS, pause_at, cap);
        run_idle(2);
        resp = cap[jtag_pkg::DMI_BITS-1:0];
    endtask

    // NOP scans until the response is no longer busy
    task automatic dmi_status(output logic [jtag_pkg::DMI_BITS-1:0] resp);
        logic [jtag_pkg::DMI_BITS-1:0] cap;
        int   tries;
        logic busy;
        tries = 0;
        busy  = 1'b1;
        cap   = '0;
        while (busy && (tries < STATUS_TRIES)) begin
            dmi_access('0, '0, jtag_pkg::DMI_OP_NOP, 0, cap);
            tries++;
            busy = (cap[jtag_pkg::DMI_OP_BITS-1:0] == jtag_pkg::DMI_RESP_BUSY);
        end
        if (busy) begin
            err_count++;
            $display("Timeout at %0t ns: DMI response still busy after %0d NOP scans",
                     $time, tries);
        end
        resp = cap;
    endtask

    task automatic dmi_check(input logic [jtag_pkg::DMI_ADDR_BITS-1:0] addr,
                             input logic [jtag_pkg::DMI_DATA_BITS-1:0] data,
                             input logic [jtag_pkg::DMI_OP_BITS-1:0] op, input int pause_at,
                             input logic [jtag_pkg::DMI_DATA_BITS-1:0] exp_data,
                             input string what);
        logic [jtag_pkg::DMI_BITS-1:0] prev;
        logic [jtag_pkg::DMI_BITS-1:0] resp;
        dmi_access(addr, data, op, pause_at, prev);
        dmi_status(resp);
        check_equal($sformatf("%s at 0x%0h", what, addr), 64'(resp),
                    64'(dmi_word(addr, exp_data, jtag_pkg::DMI_RESP_OK)));
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic test_idcode();
        logic [63:0] cap;
        logic        unused;
        int          errs;
        errs = err_count;
        tck_cycle(1'b0, 1'b0, unused);      // Leave Test-Logic-Reset
        shift_dr('0, 32, 0, cap);
        check_equal("IDCODE after reset", cap, 64'(jtag_pkg::IDCODE_VALUE));
        finish_test("idcode", errs);
    endtask

    task automatic test_dtmcs();
        logic [jtag_pkg::IR_BITS-1:0] ir_cap;
        logic [63:0]                  cap;
        logic [31:0]                  dtmcs;
        int                           errs;
        errs  = err_count;
        // idle [14:12], abits [9:4], version [3:0]
        dtmcs = (32'(jtag_pkg::DTMCS_IDLE) << 12) | (32'(jtag_pkg::DMI_ADDR_BITS) << 4)
              | 32'(jtag_pkg::DTMCS_VERSION);
        shift_ir(jtag_pkg::IR_DTMCS, ir_cap);
        check_equal("IR capture low bits", 64'(ir_cap[1:0]), 64'(2'b01));
        shift_dr('0, 32, 0, cap);
        check_equal("DTMCS value", cap, 64'(dtmcs));
        finish_test("dtmcs", errs);
    endtask

    task automatic test_bypass();
        logic [jtag_pkg::IR_BITS-1:0] ir_cap;
        logic [63:0]                  pattern;
        logic [63:0]                  cap;
        logic [63:0]                  exp_bits;
        int                           errs;
        errs = err_count;
        shift_ir(jtag_pkg::IR_BYPASS, ir_cap);
        pattern  = {$urandom, $urandom};
        shift_dr(pattern, BYPASS_BITS, 0, cap);
        exp_bits = (pattern << 1) & ((64'd1 << BYPASS_BITS) - 64'd1);  // One bit late
        check_equal("bypass delay", cap, exp_bits);
        finish_test("bypass", errs);
    endtask

    task automatic test_dmi_rw();
        logic [jtag_pkg::IR_BITS-1:0]       ir_cap;
        logic [jtag_pkg::DMI_ADDR_BITS-1:0] addr;
        logic [jtag_pkg::DMI_DATA_BITS-1:0] data;
        int                                 errs;
        errs = err_count;
        shift_ir(jtag_pkg::IR_DMI, ir_cap);
        repeat (8) begin
            addr = $urandom_range(jtag_pkg::REG_DEPTH - 1, 0);
            data = $urandom;
            dmi_check(addr, data, jtag_pkg::DMI_OP_WRITE, 0, '0, "write response");
            model[addr] = data;
        end
        for (int a = 0; a < jtag_pkg::REG_DEPTH; a++) begin
            dmi_check(jtag_pkg::DMI_ADDR_BITS'(a), '0, jtag_pkg::DMI_OP_READ, 0, model[a],
                      "read response");
        end
        finish_test("dmi read write", errs);
    endtask

    task automatic test_unmapped();
        logic [jtag_pkg::DMI_ADDR_BITS-1:0] addr;
        logic [jtag_pkg::DMI_ADDR_BITS-1:0] alias_addr;
        int                                 errs;
        errs = err_count;
        repeat (4) begin
            addr       = $urandom_range(ADDR_MAX, jtag_pkg::REG_DEPTH);
            alias_addr = addr % jtag_pkg::REG_DEPTH;
            dmi_check(addr, $urandom, jtag_pkg::DMI_OP_WRITE, 0, '0, "unmapped write");
            dmi_check(addr, '0, jtag_pkg::DMI_OP_READ, 0, '0, "unmapped read");
            dmi_check(alias_addr, '0, jtag_pkg::DMI_OP_READ, 0, model[alias_addr],
                      "word below unmapped write");
        end
        finish_test("unmapped", errs);
    endtask

    task automatic test_pause_and_reset();
        logic [jtag_pkg::IR_BITS-1:0]       ir_cap;
        logic [jtag_pkg::DMI_DATA_BITS-1:0] data;
        logic [jtag_pkg::DMI_BITS-1:0]      resp;
        logic [63:0]                        cap;
        logic                               unused;
        int                                 errs;
        errs = err_count;
        shift_ir(jtag_pkg::IR_DMI, ir_cap);
        data = $urandom;
        dmi_check(6'd5, data, jtag_pkg::DMI_OP_WRITE, 17, '0, "paused write");
        model[5] = data;
        dmi_check(6'd5, '0, jtag_pkg::DMI_OP_READ, 0, data, "read after paused write");
        // Pause while the response shifts out
        dmi_access(6'd5, '0, jtag_pkg::DMI_OP_READ, 0, resp);
        dmi_access('0, '0, jtag_pkg::DMI_OP_NOP, 23, resp);
        check_equal("paused capture", 64'(resp),
                    64'(dmi_word(6'd5, model[5], jtag_pkg::DMI_RESP_OK)));
        // Abort an IR scan into Test-Logic-Reset
        tck_cycle(1'b1, 1'b0, unused);
        tck_cycle(1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
        tck_cycle(1'b0, jtag_pkg::IR_DTMCS[0], unused);
        tck_cycle(1'b0, jtag_pkg::IR_DTMCS[1], unused);
        tap_reset();
        shift_dr('0, 32, 0, cap);
        check_equal("IDCODE after TAP reset", cap, 64'(jtag_pkg::IDCODE_VALUE));
        shift_ir(jtag_pkg::IR_DMI, ir_cap);
        dmi_check(6'd5, '0, jtag_pkg::DMI_OP_READ, 0, model[5], "read after TAP reset");
        finish_test("pause and reset", errs);
    endtask

    initial begin
        jtag_tms    = 1'b1;
        jtag_tdi    = 1'b0;
        jtag_trst_n = 1'b0;
        check_count = 0;
        err_count   = 0;
        for (int i = 0; i < jtag_pkg::REG_DEPTH; i++) begin
            model[i] = '0;
        end
        void'($urandom(32'hba1f_6570));
        repeat (2) @(posedge jtag_tck);
        @(negedge jtag_tck);
        jtag_trst_n = 1'b1;

        test_idcode();
        test_dtmcs();
        test_bypass();
        test_dmi_rw();
        test_unmapped();
        test_pause_and_reset();

        err_count += i_dut.i_dtm.i_chk_master.fail_count;
        err_count += i_dut.i_reg_file.i_chk_slave.fail_count;

        $display("Summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
source/jtag_pkg.sv
source/jtag_tap.sv
source/jtag_dtm.sv
source/dm_reg_file.sv
source/jtag_debug_top.sv
bench/jtag_debug_chk.sv
bench/jtag_debug_tb.sv

// File: source/dm_reg_file.sv
// Debug module register stand-in
`timescale 1ns/1ps

module dm_reg_file (
    input  logic                               jtag_tck_i,
    input  logic                               jtag_trst_ni,
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  logic [jtag_pkg::DMI_ADDR_BITS-1:0] wb_adr_i,
    input  logic [jtag_pkg::DMI_DATA_BITS-1:0] wb_dat_i,
    output logic [jtag_pkg::DMI_DATA_BITS-1:0] wb_dat_o,
    output logic                               wb_ack_o
);

    localparam int IDX_BITS = $clog2(jtag_pkg::REG_DEPTH);

    logic [jtag_pkg::DMI_DATA_BITS-1:0] regs_q [jtag_pkg::REG_DEPTH];
    logic [jtag_pkg::DMI_DATA_BITS-1:0] rdata_q;
    logic                               ack_q;
    logic                               access;
    logic                               in_range;
    logic [IDX_BITS-1:0]                idx;

    // First cycle of a strobe, not yet acknowledged
    assign access   = wb_cyc_i && wb_stb_i && !ack_q;
    assign in_range = (int'(wb_adr_i) < jtag_pkg::REG_DEPTH);
    assign idx      = wb_adr_i[IDX_BITS-1:0];

    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            for (int i = 0; i < jtag_pkg::REG_DEPTH; i++) begin
                regs_q[i] <= '0;
            end
        end else if (access && wb_we_i && in_range) begin
            regs_q[idx] <= wb_dat_i;    // Out-of-range writes dropped
        end
    end

    always_ff @(posedge jtag_tck_i) begin
        if (access) begin
            rdata_q <= in_range ? regs_q[idx] : '0;
        end
    end

    // Single-cycle ack, also for unmapped addresses
    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign wb_dat_o = rdata_q;
    assign wb_ack_o = ack_q;

endmodule

// File: source/jtag_debug_top.sv
// JTAG debug transport top
`timescale 1ns/1ps

module jtag_debug_top (
    input  logic jtag_tck_i,
    input  logic jtag_tms_i,
    input  logic jtag_tdi_i,
    input  logic jtag_trst_ni,
    output logic jtag_tdo_o
);

    // TAP and DTM link
    logic                               tap_req;
    logic [jtag_pkg::DMI_BITS-1:0]      tap_data;
    logic [jtag_pkg::DMI_BITS-1:0]      dtm_resp;

    // Wishbone classic
    logic                               wb_cyc;
    logic                               wb_stb;
    logic                               wb_we;
    logic [jtag_pkg::DMI_ADDR_BITS-1:0] wb_adr;
    logic [jtag_pkg::DMI_DATA_BITS-1:0] wb_dat_w;
    logic [jtag_pkg::DMI_DATA_BITS-1:0] wb_dat_r;
    logic                               wb_ack;

    jtag_tap i_tap (
        .jtag_tck_i   (jtag_tck_i),
        .jtag_trst_ni (jtag_trst_ni),
        .jtag_tms_i   (jtag_tms_i),
        .jtag_tdi_i   (jtag_tdi_i),
        .dtm_resp_i   (dtm_resp),
        .jtag_tdo_o   (jtag_tdo_o),
        .tap_req_o    (tap_req),
        .tap_data_o   (tap_data)
    );

    jtag_dtm i_dtm (
        .jtag_tck_i   (jtag_tck_i),
        .jtag_trst_ni (jtag_trst_ni),
        .tap_req_i    (tap_req),
        .tap_data_i   (tap_data),
        .wb_dat_i     (wb_dat_r),
        .wb_ack_i     (wb_ack),
        .dtm_resp_o   (dtm_resp),
        .wb_cyc_o     (wb_cyc),
        .wb_stb_o     (wb_stb),
        .wb_we_o      (wb_we),
        .wb_adr_o     (wb_adr),
        .wb_dat_o     (wb_dat_w)
    );

    // Stands in for the debug module
    dm_reg_file i_reg_file (
        .jtag_tck_i   (jtag_tck_i),
        .jtag_trst_ni (jtag_trst_ni),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_dat_i     (wb_dat_w),
        .wb_dat_o     (wb_dat_r),
        .wb_ack_o     (wb_ack)
    );

endmodule

// File: source/jtag_dtm.sv
// DMI to Wishbone bridge
`timescale 1ns/1ps

module jtag_dtm (
    input  logic                               jtag_tck_i,
    input  logic                               jtag_trst_ni,
    input  logic                               tap_req_i,
    input  logic [jtag_pkg::DMI_BITS-1:0]      tap_data_i,
    input  logic [jtag_pkg::DMI_DATA_BITS-1:0] wb_dat_i,
    input  logic                               wb_ack_i,
    output logic [jtag_pkg::DMI_BITS-1:0]      dtm_resp_o,
    output logic                               wb_cyc_o,
    output logic                               wb_stb_o,
    output logic                               wb_we_o,
    output logic [jtag_pkg::DMI_ADDR_BITS-1:0] wb_adr_o,
    output logic [jtag_pkg::DMI_DATA_BITS-1:0] wb_dat_o
);

    typedef enum logic {
        ST_IDLE,
        ST_PENDING
    } dtm_state_e;

    dtm_state_e                         state_q;

    // Request fields
    logic [jtag_pkg::DMI_ADDR_BITS-1:0] req_addr;
    logic [jtag_pkg::DMI_DATA_BITS-1:0] req_data;
    logic [jtag_pkg::DMI_OP_BITS-1:0]   req_op;
    logic                               req_access;
    logic                               req_take;

    // Bus cycle payload
    logic [jtag_pkg::DMI_ADDR_BITS-1:0] wb_adr_q;
    logic [jtag_pkg::DMI_DATA_BITS-1:0] wb_dat_q;
    logic                               wb_we_q;

    // Stored response
    logic [jtag_pkg::DMI_ADDR_BITS-1:0] resp_addr_q;
    logic [jtag_pkg::DMI_DATA_BITS-1:0] resp_data_q;
    logic                               busy;

    assign req_op   = tap_data_i[jtag_pkg::DMI_OP_BITS-1:0];
    assign req_data = tap_data_i[jtag_pkg::DMI_OP_BITS +: jtag_pkg::DMI_DATA_BITS];
    assign req_addr = tap_data_i[jtag_pkg::DMI_BITS-1 -: jtag_pkg::DMI_ADDR_BITS];

    assign req_access = (req_op == jtag_pkg::DMI_OP_READ) || (req_op == jtag_pkg::DMI_OP_WRITE);
    assign req_take   = tap_req_i && (state_q == ST_IDLE);  // Dropped while busy
    assign busy       = (state_q == ST_PENDING);

    // Idle or waiting for ack
    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_take && req_access) begin
                        state_q <= ST_PENDING;
                    end
                end
                ST_PENDING: begin
                    if (wb_ack_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Held stable for the whole bus cycle
    always_ff @(posedge jtag_tck_i) begin
        if (req_take && req_access) begin
            wb_adr_q <= req_addr;
            wb_dat_q <= req_data;
            wb_we_q  <= (req_op == jtag_pkg::DMI_OP_WRITE);
        end
    end

    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            resp_addr_q <= '0;
            resp_data_q <= '0;
        end else if (busy && wb_ack_i) begin
            resp_addr_q <= wb_adr_q;
            resp_data_q <= wb_we_q ? '0 : wb_dat_i;  // Writes return zero data
        end else if (req_take && !req_access) begin
            // NOP only refreshes the response
            resp_addr_q <= req_addr;
            resp_data_q <= '0;
        end
    end

    assign dtm_resp_o = {resp_addr_q, resp_data_q,
                         busy ? jtag_pkg::DMI_RESP_BUSY : jtag_pkg::DMI_RESP_OK};

    assign wb_cyc_o = busy;
    assign wb_stb_o = busy;     // Classic cycle, stb follows cyc
    assign wb_we_o  = wb_we_q;
    assign wb_adr_o = wb_adr_q;
    assign wb_dat_o = wb_dat_q;

endmodule

// File: source/jtag_pkg.sv
// JTAG debug transport definitions
package jtag_pkg;

    // DMI request and response layout, op in the low bits
    localparam int DMI_ADDR_BITS = 6;
    localparam int DMI_DATA_BITS = 32;
    localparam int DMI_OP_BITS   = 2;
    localparam int DMI_BITS      = DMI_ADDR_BITS + DMI_DATA_BITS + DMI_OP_BITS;

    localparam int IR_BITS = 5;    // Instruction register width

    // Instruction codes
    localparam logic [IR_BITS-1:0] IR_BYPASS = 5'b11111;
    localparam logic [IR_BITS-1:0] IR_IDCODE = 5'b00001;   // Selected after reset
    localparam logic [IR_BITS-1:0] IR_DTMCS  = 5'b10000;
    localparam logic [IR_BITS-1:0] IR_DMI    = 5'b10001;

    // Device identifier, bit 0 is always one
    localparam logic [31:0] IDCODE_VALUE = 32'h0a57_d001;

    // Fixed DTMCS fields
    localparam logic [3:0] DTMCS_VERSION = 4'd1;   // Debug spec 0.13
    localparam logic [2:0] DTMCS_IDLE    = 3'd1;   // Idle cycles hint

    // DMI request ops
    localparam logic [DMI_OP_BITS-1:0] DMI_OP_NOP   = 2'd0;
    localparam logic [DMI_OP_BITS-1:0] DMI_OP_READ  = 2'd1;
    localparam logic [DMI_OP_BITS-1:0] DMI_OP_WRITE = 2'd2;

    // DMI response status
    localparam logic [DMI_OP_BITS-1:0] DMI_RESP_OK   = 2'd0;
    localparam logic [DMI_OP_BITS-1:0] DMI_RESP_BUSY = 2'd3;

    // Words in the stand-in debug register file
    localparam int REG_DEPTH = 16;

endpackage

// File: source/jtag_tap.sv
// JTAG TAP controller
`timescale 1ns/1ps

module jtag_tap (
    input  logic                          jtag_tck_i,
    input  logic                          jtag_trst_ni,
    input  logic                          jtag_tms_i,
    input  logic                          jtag_tdi_i,
    input  logic [jtag_pkg::DMI_BITS-1:0] dtm_resp_i,
    output logic                          jtag_tdo_o,
    output logic                          tap_req_o,
    output logic [jtag_pkg::DMI_BITS-1:0] tap_data_o
);

    typedef enum logic [3:0] {
        TEST_LOGIC_RESET,
        RUN_TEST_IDLE,
        SELECT_DR,
        CAPTURE_DR,
        SHIFT_DR,
        EXIT1_DR,
        PAUSE_DR,
        EXIT2_DR,
        UPDATE_DR,
        SELECT_IR,
        CAPTURE_IR,
        SHIFT_IR,
        EXIT1_IR,
        PAUSE_IR,
        EXIT2_IR,
        UPDATE_IR
    } tap_state_e;

    // dtmcs: idle [14:12], dmistat [11:10], abits [9:4], version [3:0]
    localparam logic [31:0] DTMCS_WORD = {17'd0, jtag_pkg::DTMCS_IDLE, 2'b00,
                                          6'(jtag_pkg::DMI_ADDR_BITS),
                                          jtag_pkg::DTMCS_VERSION};

    tap_state_e                      state_q;
    tap_state_e                      state_d;
    logic [jtag_pkg::IR_BITS-1:0]    ir_q;
    logic [jtag_pkg::DMI_BITS-1:0]   shift_q;
    logic                            tap_req_q;
    logic [jtag_pkg::DMI_BITS-1:0]   tap_data_q;
    logic                            tdo_q;
    logic                            dmi_update;

    // Standard TAP transitions
    always_comb begin
        case (state_q)
            TEST_LOGIC_RESET: state_d = jtag_tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_d = jtag_tms_i ? SELECT_DR : RUN_TEST_IDLE;
            SELECT_DR:        state_d = jtag_tms_i ? SELECT_IR : CAPTURE_DR;
            CAPTURE_DR:       state_d = jtag_tms_i ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         state_d = jtag_tms_i ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         state_d = jtag_tms_i ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         state_d = jtag_tms_i ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         state_d = jtag_tms_i ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        state_d = jtag_tms_i ? SELECT_DR : RUN_TEST_IDLE;
            SELECT_IR:        state_d = jtag_tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_d = jtag_tms_i ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         state_d = jtag_tms_i ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         state_d = jtag_tms_i ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         state_d = jtag_tms_i ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         state_d = jtag_tms_i ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:        state_d = jtag_tms_i ? SELECT_DR : RUN_TEST_IDLE;
            default:          state_d = TEST_LOGIC_RESET;
        endcase
    end

    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            state_q <= TEST_LOGIC_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // Shared capture and shift register, LSB leaves first
    always_ff @(posedge jtag_tck_i) begin
        case (state_q)
            CAPTURE_IR: shift_q <= jtag_pkg::DMI_BITS'(2'b01);
            SHIFT_IR: begin
                shift_q <= jtag_pkg::DMI_BITS'({jtag_tdi_i, shift_q[jtag_pkg::IR_BITS-1:1]});
            end
            CAPTURE_DR: begin
                case (ir_q)
                    jtag_pkg::IR_IDCODE: shift_q <= jtag_pkg::DMI_BITS'(jtag_pkg::IDCODE_VALUE);
                    jtag_pkg::IR_DTMCS:  shift_q <= jtag_pkg::DMI_BITS'(DTMCS_WORD);
                    jtag_pkg::IR_DMI:    shift_q <= dtm_resp_i;
                    default:             shift_q <= '0;   // Bypass bit
                endcase
            end
            SHIFT_DR: begin
                case (ir_q)
                    jtag_pkg::IR_IDCODE,
                    jtag_pkg::IR_DTMCS: begin
                        shift_q <= jtag_pkg::DMI_BITS'({jtag_tdi_i, shift_q[31:1]});
                    end
                    jtag_pkg::IR_DMI: begin
                        shift_q <= {jtag_tdi_i, shift_q[jtag_pkg::DMI_BITS-1:1]};
                    end
                    default: shift_q <= jtag_pkg::DMI_BITS'(jtag_tdi_i);  // One-bit path
                endcase
            end
            default: shift_q <= shift_q;
        endcase
    end

    assign dmi_update = (state_q == UPDATE_DR) && (ir_q == jtag_pkg::IR_DMI);

    // Request pulse on the edge leaving UPDATE_DR
    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            tap_req_q <= 1'b0;
        end else begin
            tap_req_q <= dmi_update;
        end
    end

    always_ff @(posedge jtag_tck_i) begin
        if (dmi_update) begin
            tap_data_q <= shift_q;
        end
    end

    // Instruction and TDO change on the falling edge
    always_ff @(negedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            ir_q <= jtag_pkg::IR_IDCODE;
        end else if (state_q == TEST_LOGIC_RESET) begin
            ir_q <= jtag_pkg::IR_IDCODE;
        end else if (state_q == UPDATE_IR) begin
            ir_q <= shift_q[jtag_pkg::IR_BITS-1:0];
        end
    end

    always_ff @(negedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            tdo_q <= 1'b0;
        end else begin
            tdo_q <= ((state_q == SHIFT_IR) || (state_q == SHIFT_DR)) ? shift_q[0] : 1'b0;
        end
    end

    assign jtag_tdo_o = tdo_q;
    assign tap_req_o  = tap_req_q;
    assign tap_data_o = tap_data_q;

endmodule
